//--- cache_defines.svh
// cache geometry macros shared by the package and the cache RTL
`ifndef CACHE_DEFINES_SVH
`define CACHE_DEFINES_SVH

//////////////////////////////////////////////////
// base geometry
//////////////////////////////////////////////////

// number of sets
`define CACHE_NUM_LINES 8

// ways per set
`define CACHE_WAYS 2

// bits per line
`define CACHE_LINE_WIDTH 128

// line address width
`define CACHE_ADDR_WIDTH 12

// derived address fields
`define CACHE_INDEX_WIDTH $clog2(`CACHE_NUM_LINES)
`define CACHE_TAG_WIDTH (`CACHE_ADDR_WIDTH - `CACHE_INDEX_WIDTH)

`endif

//--- cache_lru.sv
// per-set least recently used tracking for the two-way cache
`timescale 1ns/1ns
`include "cache_defines.svh"

module cache_lru
    import cache_pkg::*;
(
    input  logic   clk,
    input  logic   rst_n,

    // update from the controller
    input  logic   load,
    input  index_t index,
    input  way_t   mru,

    // replacement candidate for the addressed set
    output way_t   lru
);

    //////////////////////////////////////////////////
    // lru table
    //////////////////////////////////////////////////

    // one entry per set naming the victim way
    way_t lru_q [`CACHE_NUM_LINES];

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            for (int s = 0; s < `CACHE_NUM_LINES; s++) begin
                lru_q[s] <= '0;
            end
        end else if (load) begin
            // with two ways the victim is simply the other one
            lru_q[index] <= ~mru;
        end
    end

    assign lru = lru_q[index];

endmodule : cache_lru

//--- cache_pkg.sv
// shared types for the read-only cache, bus request structs and controller states
`include "cache_defines.svh"

package cache_pkg;

    // meaningful widths
    typedef logic [`CACHE_ADDR_WIDTH-1:0]       line_addr_t;
    typedef logic [`CACHE_TAG_WIDTH-1:0]        tag_t;
    typedef logic [`CACHE_INDEX_WIDTH-1:0]      index_t;
    typedef logic [$clog2(`CACHE_WAYS)-1:0]     way_t;
    typedef logic [`CACHE_WAYS-1:0]             way_mask_t;
    typedef logic [`CACHE_LINE_WIDTH-1:0]       line_t;

    // wishbone classic request, cpu side
    typedef struct packed {
        logic       cyc;
        logic       stb;
        line_addr_t adr;
    } cpu_req_t;

    // wishbone classic request, memory side
    typedef struct packed {
        logic       cyc;
        logic       stb;
        line_addr_t adr;
    } mem_req_t;

    // controller states
    typedef enum logic [1:0] {
        state_idle,
        state_fill,
        state_ack
    } ctrl_state_t;

endpackage : cache_pkg

//--- cache_way.sv
// single cache way with valid, tag and data storage per set
`timescale 1ns/1ns
`include "cache_defines.svh"

module cache_way
    import cache_pkg::*;
(
    input  logic   clk,
    input  logic   rst_n,

    // fill side
    input  logic   load,
    input  index_t index,
    input  tag_t   tag,
    input  line_t  fill_dat,

    // lookup side
    output logic   hit,
    output line_t  rd_dat
);

    //////////////////////////////////////////////////
    // storage
    //////////////////////////////////////////////////

    logic [`CACHE_NUM_LINES-1:0] valid_q;
    tag_t                        tag_q  [`CACHE_NUM_LINES];
    line_t                       data_q [`CACHE_NUM_LINES];

    // valid bits are the only control state here
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            valid_q <= '0;
        end else if (load) begin
            valid_q[index] <= 1'b1;
        end
    end

    // tag and line written together on a fill
    always_ff @(posedge clk) begin
        if (load) begin
            tag_q[index]  <= tag;
            data_q[index] <= fill_dat;
        end
    end

    //////////////////////////////////////////////////
    // lookup
    //////////////////////////////////////////////////

    // combinational compare against the addressed set
    always_comb begin
        hit    = valid_q[index] && (tag_q[index] == tag);
        rd_dat = data_q[index];
    end

endmodule : cache_way

//--- readonly_cache.sv
// two-way read-only line cache between a cpu wishbone port and a memory wishbone port
`timescale 1ns/1ns

module readonly_cache
    import cache_pkg::*;
(
    input  logic     clk,
    input  logic     rst_n,

    // cpu side, wishbone classic slave
    input  cpu_req_t cpu_req,
    output logic     cpu_ack,
    output line_t    cpu_dat,

    // memory side, wishbone classic master
    output mem_req_t mem_req,
    input  logic     mem_ack,
    input  line_t    mem_dat
);

    //////////////////////////////////////////////////
    // controller <-> datapath
    //////////////////////////////////////////////////

    way_t      way_sel;
    logic      load;
    logic      load_lru;
    way_mask_t hit;
    way_t      lru;

    readonly_cache_control readonly_cache_control_inst (
        .clk      (clk),
        .rst_n    (rst_n),
        .cpu_req  (cpu_req),
        .cpu_ack  (cpu_ack),
        .mem_req  (mem_req),
        .mem_ack  (mem_ack),
        .hit      (hit),
        .lru      (lru),
        .way_sel  (way_sel),
        .load     (load),
        .load_lru (load_lru)
    );

    // cpu address drives the lookup, fills come straight from memory
    readonly_cache_datapath readonly_cache_datapath_inst (
        .clk      (clk),
        .rst_n    (rst_n),
        .adr      (cpu_req.adr),
        .way_sel  (way_sel),
        .load     (load),
        .load_lru (load_lru),
        .fill_dat (mem_dat),
        .hit      (hit),
        .lru      (lru),
        .rd_dat   (cpu_dat)
    );

endmodule : readonly_cache

//--- readonly_cache_control.sv
// cache controller FSM sequencing lookup, line fill and cpu acknowledge
`timescale 1ns/1ns
`include "cache_defines.svh"

module readonly_cache_control
    import cache_pkg::*;
(
    input  logic      clk,
    input  logic      rst_n,

    // cpu wishbone slave side
    input  cpu_req_t  cpu_req,
    output logic      cpu_ack,

    // memory wishbone master side
    output mem_req_t  mem_req,
    input  logic      mem_ack,

    // datapath status
    input  way_mask_t hit,
    input  way_t      lru,

    // datapath control
    output way_t      way_sel,
    output logic      load,
    output logic      load_lru
);

    ctrl_state_t state;
    ctrl_state_t next_state;
    logic        req_valid;
    way_t        hit_way;

    assign req_valid = cpu_req.cyc && cpu_req.stb;

    // encode the hit mask into a way number
    always_comb begin
        hit_way = '0;
        for (int w = 0; w < `CACHE_WAYS; w++) begin
            if (hit[w]) begin
                hit_way = way_t'(w);
            end
        end
    end

    //////////////////////////////////////////////////
    // state register
    //////////////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state <= state_idle;
        end else begin
            state <= next_state;
        end
    end

    //////////////////////////////////////////////////
    // next state and datapath control
    //////////////////////////////////////////////////

    always_comb begin
        next_state = state;
        // victim way unless a hit says otherwise
        way_sel    = lru;
        load       = 1'b0;
        load_lru   = 1'b0;
        case (state)
            state_idle: begin
                if (req_valid) begin
                    if (|hit) begin
                        way_sel    = hit_way;
                        load_lru   = 1'b1;
                        next_state = state_ack;
                    end else begin
                        next_state = state_fill;
                    end
                end
            end
            state_fill: begin
                // lru is stable here, set and address are held by the cpu
                if (mem_ack) begin
                    load       = 1'b1;
                    next_state = state_idle;
                end
            end
            state_ack: begin
                next_state = state_idle;
            end
            default: begin
                next_state = state_idle;
            end
        endcase
    end

    // bus outputs decoded from state
    assign cpu_ack     = (state == state_ack);
    assign mem_req.cyc = (state == state_fill);
    assign mem_req.stb = (state == state_fill);
    assign mem_req.adr = cpu_req.adr;

endmodule : readonly_cache_control

//--- readonly_cache_datapath.sv
// cache datapath with address split, way storage, lru table and read data select
`timescale 1ns/1ns
`include "cache_defines.svh"

module readonly_cache_datapath
    import cache_pkg::*;
(
    input  logic       clk,
    input  logic       rst_n,

    // cpu side address
    input  line_addr_t adr,

    // from the controller
    input  way_t       way_sel,
    input  logic       load,
    input  logic       load_lru,

    // line returned by memory
    input  line_t      fill_dat,

    // to the controller
    output way_mask_t  hit,
    output way_t       lru,

    // to the cpu
    output line_t      rd_dat
);

    //////////////////////////////////////////////////
    // address split
    //////////////////////////////////////////////////

    tag_t   tag;
    index_t index;

    assign index = adr[`CACHE_INDEX_WIDTH-1:0];
    assign tag   = adr[`CACHE_ADDR_WIDTH-1:`CACHE_INDEX_WIDTH];

    //////////////////////////////////////////////////
    // ways
    //////////////////////////////////////////////////

    way_mask_t way_load;
    line_t     way_dat [`CACHE_WAYS];

    // only the selected way takes the fill
    always_comb begin
        for (int w = 0; w < `CACHE_WAYS; w++) begin
            way_load[w] = load && (way_sel == way_t'(w));
        end
    end

    for (genvar w = 0; w < `CACHE_WAYS; w++) begin : g_way
        cache_way cache_way_inst (
            .clk      (clk),
            .rst_n    (rst_n),
            .load     (way_load[w]),
            .index    (index),
            .tag      (tag),
            .fill_dat (fill_dat),
            .hit      (hit[w]),
            .rd_dat   (way_dat[w])
        );
    end

    //////////////////////////////////////////////////
    // lru
    //////////////////////////////////////////////////

    // the way being answered becomes most recently used
    cache_lru cache_lru_inst (
        .clk   (clk),
        .rst_n (rst_n),
        .load  (load_lru),
        .index (index),
        .mru   (way_sel),
        .lru   (lru)
    );

    //////////////////////////////////////////////////
    // read data
    //////////////////////////////////////////////////

    // captured with the lru update, so it holds through the ack cycle
    always_ff @(posedge clk) begin
        if (load_lru) begin
            rd_dat <= way_dat[way_sel];
        end
    end

endmodule : readonly_cache_datapath

//--- readonly_cache_tb.sv
// testbench for the read-only cache, random reads checked against a reference cache model
`timescale 1ns/1ns
`include "cache_defines.svh"

module readonly_cache_tb
    import cache_pkg::*;
();

    localparam int NUM_ACCESSES = 400;
    localparam int NUM_DIRECTED = 6;
    localparam int RESET_CYCLES = 5;
    localparam int POOL_SIZE    = 12;
    localparam int CYCLE_LIMIT  = (NUM_ACCESSES + NUM_DIRECTED) * 12 + RESET_CYCLES + 10;

    logic     clk;
    logic     rst_n;
    cpu_req_t cpu_req;
    logic     cpu_ack;
    line_t    cpu_dat;
    mem_req_t mem_req;
    logic     mem_ack;
    line_t    mem_dat;

    readonly_cache readonly_cache_inst (
        .clk     (clk),
        .rst_n   (rst_n),
        .cpu_req (cpu_req),
        .cpu_ack (cpu_ack),
        .cpu_dat (cpu_dat),
        .mem_req (mem_req),
        .mem_ack (mem_ack),
        .mem_dat (mem_dat)
    );

    // memory contents and per-access wait count
    line_t       mem_lines [1 << `CACHE_ADDR_WIDTH];
    int          mem_wait_cfg;
    int          wait_left = -1;

    // reference cache state
    bit          m_valid [`CACHE_NUM_LINES][`CACHE_WAYS];
    tag_t        m_tag   [`CACHE_NUM_LINES][`CACHE_WAYS];
    way_t        m_lru   [`CACHE_NUM_LINES];

    line_addr_t  pool [POOL_SIZE];
    int          errors;
    int          hits;
    int          misses;
    int          cycle_count;
    ctrl_state_t stuck_state;

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    //////////////////////////////////////////////////
    // memory model and watchdog
    //////////////////////////////////////////////////

    // answers a held request after mem_wait_cfg extra cycles
    always @(posedge clk) begin
        if (mem_ack) begin
            mem_ack   <= 1'b0;
            wait_left = -1;
        end else if (mem_req.cyc && mem_req.stb) begin
            if (wait_left < 0) begin
                wait_left = mem_wait_cfg;
            end
            if (wait_left == 0) begin
                mem_ack <= 1'b1;
                mem_dat <= mem_lines[mem_req.adr];
            end else begin
                wait_left--;
            end
        end
    end

    always @(posedge clk) begin
        cycle_count++;
        if (cycle_count >= CYCLE_LIMIT) begin
            stuck_state = readonly_cache_inst.readonly_cache_control_inst.state;
            $display("timeout after %0d cycles, controller stuck in %s",
                     cycle_count, stuck_state.name());
            $display("Something failed");
            $finish;
        end
    end

    //////////////////////////////////////////////////
    // one cpu read with all checks
    //////////////////////////////////////////////////

    task automatic run_access(input line_addr_t addr, output bit dut_miss);
        index_t set;
        tag_t   tg;
        bit     pred_hit;
        way_t   pred_way;
        int     k;
        int     ack_cyc;
        int     mem_ack_cyc;
        int     first_stb_cyc;
        int     stb_rises;
        int     mem_acks;
        bit     prev_stb;
        bit     done;

        set           = addr[`CACHE_INDEX_WIDTH-1:0];
        tg            = addr[`CACHE_ADDR_WIDTH-1:`CACHE_INDEX_WIDTH];
        pred_hit      = 1'b0;
        pred_way      = m_lru[set];
        for (int w = 0; w < `CACHE_WAYS; w++) begin
            if (m_valid[set][w] && m_tag[set][w] == tg) begin
                pred_hit = 1'b1;
                pred_way = way_t'(w);
            end
        end
        k             = 0;
        ack_cyc       = 0;
        mem_ack_cyc   = 0;
        first_stb_cyc = 0;
        stb_rises     = 0;
        mem_acks      = 0;
        prev_stb      = 1'b0;
        done          = 1'b0;
        mem_wait_cfg  = $urandom_range(4, 0);

        @(posedge clk);
        // the previous ack is one cycle wide
        assert (!cpu_ack) else begin
            errors++;
            $display("cpu_ack still high before the request at %0t", $time);
        end
        cpu_req <= {1'b1, 1'b1, addr};
        while (!done) begin
            @(posedge clk);
            k++;
            if (mem_req.stb) begin
                if (!prev_stb) begin
                    stb_rises++;
                    if (first_stb_cyc == 0) begin
                        first_stb_cyc = k;
                    end
                end
                assert (mem_req.cyc) else begin
                    errors++;
                    $display("mem_stb raised without mem_cyc at %0t", $time);
                end
                assert (mem_req.adr == addr) else begin
                    errors++;
                    $display("MISMATCH at %0t: mem_adr exp %h got %h", $time, addr, mem_req.adr);
                end
                assert (mem_ack_cyc == 0) else begin
                    errors++;
                    $display("memory request still raised after mem_ack at %0t", $time);
                end
            end
            prev_stb = mem_req.stb;
            if (mem_ack) begin
                mem_acks++;
                mem_ack_cyc = k;
            end
            if (cpu_ack) begin
                ack_cyc = k;
                done    = 1'b1;
                assert (cpu_dat == mem_lines[addr]) else begin
                    errors++;
                    $display("MISMATCH at %0t: cpu_dat exp %h got %h",
                             $time, mem_lines[addr], cpu_dat);
                end
                cpu_req <= '0;
            end
        end

        if (pred_hit) begin
            hits++;
            // request seen in cycle 1, ack in cycle 2
            assert (ack_cyc == 2) else begin
                errors++;
                $display("MISMATCH at %0t: cpu_ack cycle exp 2 got %0d", $time, ack_cyc);
            end
            assert (stb_rises == 0 && mem_acks == 0) else begin
                errors++;
                $display("memory read on a predicted hit to %h at %0t", addr, $time);
            end
        end else begin
            misses++;
            assert (stb_rises == 1 && mem_acks == 1) else begin
                errors++;
                $display("expected one memory read for %h, saw %0d requests and %0d acks",
                         addr, stb_rises, mem_acks);
            end
            assert (first_stb_cyc == 2) else begin
                errors++;
                $display("MISMATCH at %0t: mem_stb cycle exp 2 got %0d", $time, first_stb_cyc);
            end
            assert (ack_cyc == mem_ack_cyc + 2) else begin
                errors++;
                $display("MISMATCH at %0t: cpu_ack cycle exp %0d got %0d",
                         $time, mem_ack_cyc + 2, ack_cyc);
            end
            m_valid[set][pred_way] = 1'b1;
            m_tag[set][pred_way]   = tg;
        end
        // the answered way becomes most recently used
        m_lru[set] = way_t'(1 - pred_way);
        dut_miss   = (mem_acks != 0);
    endtask

    //////////////////////////////////////////////////
    // main sequence
    //////////////////////////////////////////////////

    line_addr_t dir_addr [NUM_DIRECTED];
    bit         dir_miss [NUM_DIRECTED];
    bit         miss_seen;

    initial begin
        void'($urandom(32'hbf39));
        clk         = 1'b0;
        rst_n       = 1'b0;
        cpu_req     = '0;
        mem_ack     = 1'b0;
        mem_dat     = '0;
        errors      = 0;
        hits        = 0;
        misses      = 0;
        cycle_count = 0;
        // model starts like a reset cache, victim way 0 everywhere
        for (int s = 0; s < `CACHE_NUM_LINES; s++) begin
            m_lru[s] = '0;
        end
        for (int a = 0; a < (1 << `CACHE_ADDR_WIDTH); a++) begin
            mem_lines[a] = {$urandom, $urandom, $urandom, $urandom};
        end
        // three tags per set over four sets
        for (int i = 0; i < POOL_SIZE; i++) begin
            pool[i] = {tag_t'($urandom_range(511, 0)), index_t'(i % 4)};
        end

        repeat (RESET_CYCLES) @(posedge clk);
        rst_n <= 1'b1;
        repeat (3) begin
            @(posedge clk);
            assert (!cpu_ack && !mem_req.cyc && !mem_req.stb) else begin
                errors++;
                $display("bus active while idle after reset at %0t", $time);
            end
        end

        // A, B, A, C, A, B in set 5, C evicts B
        dir_addr = '{{9'h011, 3'd5}, {9'h022, 3'd5}, {9'h011, 3'd5},
                     {9'h033, 3'd5}, {9'h011, 3'd5}, {9'h022, 3'd5}};
        dir_miss = '{1'b1, 1'b1, 1'b0, 1'b1, 1'b0, 1'b1};
        for (int i = 0; i < NUM_DIRECTED; i++) begin
            run_access(dir_addr[i], miss_seen);
            assert (miss_seen == dir_miss[i]) else begin
                errors++;
                $display("directed access %0d to %h: replacement order is wrong", i, dir_addr[i]);
            end
        end

        for (int n = 0; n < NUM_ACCESSES; n++) begin
            repeat ($urandom_range(2, 0)) @(posedge clk);
            run_access(pool[$urandom_range(POOL_SIZE - 1, 0)], miss_seen);
        end

        $display("accesses %0d, hits %0d, misses %0d, errors %0d",
                 hits + misses, hits, misses, errors);
        if (errors == 0) begin
            $display("Everything OK");
        end else begin
            $display("Something failed");
        end
        $finish;
    end

endmodule : readonly_cache_tb

//--- tb.f
+incdir+.
cache_pkg.sv
cache_way.sv
cache_lru.sv
readonly_cache_datapath.sv
readonly_cache_control.sv
readonly_cache.sv
readonly_cache_tb.sv
